// File: gpr_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General register file
// Eight 32-bit registers with one writeback port and the string
// move stepping of ESI and EDI
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gpr_file (
    input  logic             clk,
    input  logic             reset,
    input  logic             accept,
    input  ra_pkg::decode_t  d_instr,
    input  ra_pkg::wb_t      wb,
    input  logic             flag_df,
    output ra_pkg::gpr_set_t regs
);

    ra_pkg::gpr_set_t gpr_q;

    logic [ra_pkg::data_width-1:0] step;
    logic [ra_pkg::data_width-1:0] esi_cur;
    logic [ra_pkg::data_width-1:0] edi_cur;
    logic [ra_pkg::data_width-1:0] esi_next;
    logic [ra_pkg::data_width-1:0] edi_next;
    logic                          movs_step;

    assign esi_cur = gpr_q[ra_pkg::reg_esi];
    assign edi_cur = gpr_q[ra_pkg::reg_edi];

    // Step is the operand size in bytes
    assign step      = ra_pkg::size_bytes(d_instr.size);
    assign movs_step = accept && d_instr.movs;

    // DF set walks the strings downward
    always_comb begin
        if (flag_df) begin
            esi_next = esi_cur - step;
            edi_next = edi_cur - step;
        end else begin
            esi_next = esi_cur + step;
            edi_next = edi_cur + step;
        end
    end

    // Writeback comes last so it overrides a same-cycle step
    always_ff @(posedge clk) begin
        if (reset) begin
            gpr_q <= '0;
        end else begin
            if (movs_step) begin
                gpr_q[ra_pkg::reg_esi] <= esi_next;
                gpr_q[ra_pkg::reg_edi] <= edi_next;
            end
            if (wb.en) begin
                gpr_q[wb.num] <= wb.data;
            end
        end
    end

    // Read side shows the registers before this cycle's updates
    assign regs = gpr_q;

    // Writeback unit must present a known register number
    wb_num_known: assert property (
        @(posedge clk) disable iff (reset)
        wb.en |-> !$isunknown(wb.num)
    );

endmodule

// File: operand_select.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand select
// Resolves both operand register numbers of a decoded instruction,
// taking ModRM rm where the selector asks for it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_select (
    input  ra_pkg::decode_t                    d_instr,
    output logic [ra_pkg::reg_num_width-1:0]   op0_reg,
    output logic [ra_pkg::reg_num_width-1:0]   op1_reg
);

    // rm field of ModRM, shared by both operands
    logic [ra_pkg::reg_num_width-1:0] modrm_rm;

    assign modrm_rm = d_instr.modrm[2:0];

    function automatic logic [ra_pkg::reg_num_width-1:0] resolve_reg(
        input logic [2:0]                       sel,
        input logic [ra_pkg::reg_num_width-1:0] decoded,
        input logic [ra_pkg::reg_num_width-1:0] rm
    );
        if (sel == ra_pkg::op_modrm_rm) begin
            return rm;
        end
        return decoded;
    endfunction

    // Destination side operand
    always_comb begin
        op0_reg = resolve_reg(d_instr.op0, d_instr.op0_reg, modrm_rm);
    end

    // Source side operand
    always_comb begin
        op1_reg = resolve_reg(d_instr.op1, d_instr.op1_reg, modrm_rm);
    end

endmodule

// File: ra_output_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output pipeline register
// One-entry valid/ready stage toward address generation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ra_output_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           d_valid,
    output logic           d_ready,
    output logic           accept,
    input  ra_pkg::issue_t issue_in,
    output logic           r_valid,
    input  logic           r_ready,
    output ra_pkg::issue_t r_instr
);

    logic           valid_q;
    ra_pkg::issue_t instr_q;

    // Room when empty or when the held entry leaves this cycle
    assign d_ready = !valid_q || r_ready;
    assign accept  = d_valid && d_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (r_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= issue_in;
        end
    end

    assign r_valid = valid_q;
    assign r_instr = instr_q;

    // Stalled output holds until taken
    output_hold: assert property (
        @(posedge clk) disable iff (reset)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_instr))
    );

endmodule

// File: ra_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage definitions
// Field widths, register numbers, operand size codes and the
// instruction records exchanged with decode and address generation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ra_pkg;

    localparam int data_width    = 32;
    localparam int reg_num_width = 3;
    localparam int gpr_count     = 8;

    // Register numbers the stage acts on by itself
    localparam logic [reg_num_width-1:0] reg_esp = 3'd4;
    localparam logic [reg_num_width-1:0] reg_esi = 3'd6;
    localparam logic [reg_num_width-1:0] reg_edi = 3'd7;

    // Operand selector meaning the register sits in ModRM rm
    localparam logic [2:0] op_modrm_rm = 3'd4;

    typedef logic [1:0] size_t;

    localparam size_t size_byte  = 2'd1;
    localparam size_t size_word  = 2'd2;
    localparam size_t size_dword = 2'd3;

    typedef struct packed {
        logic pop;
        logic push;
    } stack_op_t;

    // Instruction as delivered by decode
    typedef struct packed {
        size_t                    size;
        logic [2:0]               op0;
        logic [2:0]               op1;
        logic [reg_num_width-1:0] op0_reg;
        logic [reg_num_width-1:0] op1_reg;
        logic [7:0]               modrm;
        stack_op_t                stack_op;
        logic                     movs;
        logic [data_width-1:0]    imm;
        logic [data_width-1:0]    pc;
    } decode_t;

    // Indexed by register number, eax at 0
    typedef logic [gpr_count-1:0][data_width-1:0] gpr_set_t;

    typedef struct packed {
        logic                     en;
        logic [reg_num_width-1:0] num;
        logic                     stack;
        logic [data_width-1:0]    data;
    } wb_t;

    // Instruction handed to address generation
    typedef struct packed {
        size_t                    size;
        logic [2:0]               op0;
        logic [2:0]               op1;
        logic [reg_num_width-1:0] op0_reg;
        logic [reg_num_width-1:0] op1_reg;
        logic [7:0]               modrm;
        logic [data_width-1:0]    imm;
        logic [data_width-1:0]    pc;
        stack_op_t                stack_op;
        logic [data_width-1:0]    stack_address;
        gpr_set_t                 regs;
    } issue_t;

    // Byte count of an operand size code
    function automatic logic [data_width-1:0] size_bytes(input size_t size);
        case (size)
            size_byte:  return 32'd1;
            size_word:  return 32'd2;
            size_dword: return 32'd4;
            default:    return '0;
        endcase
    endfunction

endpackage

// File: register_access_cases.txt
# 1 num stack data : writeback held for one cycle
# 2 size op0 op1 op0_reg op1_reg modrm stack_op movs df imm pc ready_mode exp_op0 exp_op1
2 3 4 1 2 5 c3 0 0 0 00000011 00001000 0 3 5
1 0 0 11111110
1 1 0 22222221
1 2 0 33333332
1 3 0 44444443
1 5 0 55555554
1 6 0 00001000
1 7 0 00002000
1 4 0 00008000
2 3 1 4 6 0 fd 0 0 0 00000022 00001004 0 6 5
2 1 0 0 0 0 00 0 1 0 00000000 00001008 0 0 0
2 2 0 0 0 0 00 0 1 0 00000000 0000100a 0 0 0
2 3 0 0 0 0 00 0 1 1 00000000 0000100c 0 0 0
2 1 0 0 0 0 00 0 1 1 00000000 0000100e 0 0 0
2 3 2 0 1 0 00 1 0 0 00000000 00001010 0 1 0
2 2 2 0 3 0 00 1 0 0 00000000 00001012 0 3 0
2 2 2 0 3 0 00 2 0 0 00000000 00001014 0 3 0
1 4 1 12345678
2 3 2 0 0 0 00 2 0 0 00000000 00001016 0 0 0
1 4 0 00010000
2 3 4 4 0 0 d7 1 0 0 000000aa 00001018 1 7 7
2 2 1 4 2 0 e1 0 1 0 000000bb 0000101c 1 2 1
2 3 0 0 0 0 00 2 0 0 000000cc 00001020 1 0 0
2 1 4 0 5 6 ca 0 1 1 000000dd 00001024 1 2 6
2 3 0 0 0 0 00 1 0 0 000000ee 00001028 1 0 0
2 2 4 2 1 3 f9 2 0 0 000000ff 0000102c 1 1 3
2 3 0 0 0 0 00 0 0 0 00000000 00001030 0 0 0

// File: register_access_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage
// Resolves operands, snapshots the registers, tracks the stack
// pointer and registers the result toward address generation
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module register_access_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            d_valid,
    output logic            d_ready,
    input  ra_pkg::decode_t d_instr,
    output logic            r_valid,
    input  logic            r_ready,
    output ra_pkg::issue_t  r_instr,
    input  ra_pkg::wb_t     wb,
    input  logic            flag_df
);

    logic                             accept;
    logic [ra_pkg::reg_num_width-1:0] op0_reg;
    logic [ra_pkg::reg_num_width-1:0] op1_reg;
    logic [ra_pkg::data_width-1:0]    stack_address;
    ra_pkg::gpr_set_t                 regs;
    ra_pkg::issue_t                   issue_in;

    operand_select u_operand_select (
        .d_instr (d_instr),
        .op0_reg (op0_reg),
        .op1_reg (op1_reg)
    );

    gpr_file u_gpr_file (
        .clk     (clk),
        .reset   (reset),
        .accept  (accept),
        .d_instr (d_instr),
        .wb      (wb),
        .flag_df (flag_df),
        .regs    (regs)
    );

    stack_tracker u_stack_tracker (
        .clk           (clk),
        .reset         (reset),
        .accept        (accept),
        .d_instr       (d_instr),
        .wb            (wb),
        .stack_address (stack_address)
    );

    // Decode fields plus everything resolved in this stage
    always_comb begin
        issue_in.size          = d_instr.size;
        issue_in.op0           = d_instr.op0;
        issue_in.op1           = d_instr.op1;
        issue_in.op0_reg       = op0_reg;
        issue_in.op1_reg       = op1_reg;
        issue_in.modrm         = d_instr.modrm;
        issue_in.imm           = d_instr.imm;
        issue_in.pc            = d_instr.pc;
        issue_in.stack_op      = d_instr.stack_op;
        issue_in.stack_address = stack_address;
        issue_in.regs          = regs;
    end

    ra_output_stage u_ra_output_stage (
        .clk      (clk),
        .reset    (reset),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .accept   (accept),
        .issue_in (issue_in),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_instr  (r_instr)
    );

endmodule

// File: stack_tracker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stack tracker
// Working stack pointer ahead of the architectural ESP and the
// push/pop stack address of the accepted instruction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stack_tracker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          accept,
    input  ra_pkg::decode_t               d_instr,
    input  ra_pkg::wb_t                   wb,
    output logic [ra_pkg::data_width-1:0] stack_address
);

    logic [ra_pkg::data_width-1:0] esp_q;
    logic [ra_pkg::data_width-1:0] step;
    logic [ra_pkg::data_width-1:0] esp_push;
    logic [ra_pkg::data_width-1:0] esp_pop;
    logic                          esp_reload;
    logic                          do_push;
    logic                          do_pop;

    assign step     = ra_pkg::size_bytes(d_instr.size);
    assign esp_push = esp_q - step;
    assign esp_pop  = esp_q + step;

    assign do_push = accept && d_instr.stack_op.push;
    assign do_pop  = accept && d_instr.stack_op.pop;

    // Non-stack write to ESP, e.g. a mov, resyncs the working copy
    assign esp_reload = wb.en && !wb.stack && (wb.num == ra_pkg::reg_esp);

    // Pop reads at ESP, push writes below it
    always_comb begin
        if (d_instr.stack_op.pop) begin
            stack_address = esp_q;
        end else if (d_instr.stack_op.push) begin
            stack_address = esp_push;
        end else begin
            stack_address = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            esp_q <= '0;
        end else if (esp_reload) begin
            esp_q <= wb.data;
        end else if (do_push) begin
            esp_q <= esp_push;
        end else if (do_pop) begin
            esp_q <= esp_pop;
        end
    end

    // Decode never marks an instruction as both push and pop
    push_pop_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        accept |-> !(d_instr.stack_op.push && d_instr.stack_op.pop)
    );

endmodule

// File: tb_register_access.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register access stage testbench
// Replays the cases file against a register and stack pointer model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_register_access;

    logic            clk;
    logic            reset;
    logic            d_valid;
    logic            d_ready;
    ra_pkg::decode_t d_instr;
    logic            r_valid;
    logic            r_ready;
    ra_pkg::issue_t  r_instr;
    ra_pkg::wb_t     wb;
    logic            flag_df;

    ra_pkg::issue_t  expected_q[$];
    string           case_lines[$];
    logic [31:0]     model_regs[8];
    logic [31:0]     model_esp;
    logic [31:0]     lcg_state;
    logic            stall_mode;
    int              case_count;

    register_access_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d_instr (d_instr),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_instr (r_instr),
        .wb      (wb),
        .flag_df (flag_df)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Size code 3 is a doubleword, codes 1 and 2 count themselves
    function automatic logic [31:0] operand_bytes(input logic [1:0] size);
        return (size == 2'd3) ? 32'd4 : {30'd0, size};
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_issue(input ra_pkg::issue_t exp);
        check_value("r_instr.size", r_instr.size, exp.size);
        check_value("r_instr.op0", r_instr.op0, exp.op0);
        check_value("r_instr.op1", r_instr.op1, exp.op1);
        check_value("r_instr.op0_reg", r_instr.op0_reg, exp.op0_reg);
        check_value("r_instr.op1_reg", r_instr.op1_reg, exp.op1_reg);
        check_value("r_instr.modrm", r_instr.modrm, exp.modrm);
        check_value("r_instr.imm", r_instr.imm, exp.imm);
        check_value("r_instr.pc", r_instr.pc, exp.pc);
        check_value("r_instr.stack_op", r_instr.stack_op, exp.stack_op);
        check_value("r_instr.stack_address", r_instr.stack_address, exp.stack_address);
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("r_instr.regs[%0d]", i), r_instr.regs[i], exp.regs[i]);
        end
    endtask

    // One cycle write, seen by the next accepted instruction
    task automatic apply_writeback(input logic [31:0] num, input logic [31:0] stk,
                                   input logic [31:0] data);
        wb.en    = 1'b1;
        wb.num   = num[2:0];
        wb.stack = stk[0];
        wb.data  = data;
        model_regs[num[2:0]] = data;
        // Only a non-stack write to ESP moves the working copy
        if (num[2:0] == 3'd4 && !stk[0]) begin
            model_esp = data;
        end
        @(negedge clk);
        wb.en = 1'b0;
    endtask

    task automatic issue_instruction(input string line);
        logic [31:0]    f[15];
        logic [31:0]    bytes;
        ra_pkg::issue_t exp;
        void'($sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14]));
        d_instr.size     = f[1][1:0];
        d_instr.op0      = f[2][2:0];
        d_instr.op1      = f[3][2:0];
        d_instr.op0_reg  = f[4][2:0];
        d_instr.op1_reg  = f[5][2:0];
        d_instr.modrm    = f[6][7:0];
        d_instr.stack_op = f[7][1:0];
        d_instr.movs     = f[8][0];
        d_instr.imm      = f[10];
        d_instr.pc       = f[11];
        flag_df          = f[9][0];
        stall_mode       = f[12][0];
        d_valid          = 1'b1;
        // Accept happens at the next rising edge when ready is seen here
        #1;
        while (!d_ready) begin
            @(negedge clk);
            #1;
        end
        bytes             = operand_bytes(f[1][1:0]);
        exp.size          = f[1][1:0];
        exp.op0           = f[2][2:0];
        exp.op1           = f[3][2:0];
        exp.op0_reg       = f[13][2:0];
        exp.op1_reg       = f[14][2:0];
        exp.modrm         = f[6][7:0];
        exp.imm           = f[10];
        exp.pc            = f[11];
        exp.stack_op      = f[7][1:0];
        exp.stack_address = f[7][1] ? model_esp : (f[7][0] ? model_esp - bytes : 32'd0);
        for (int i = 0; i < 8; i++) begin
            exp.regs[i] = model_regs[i];
        end
        expected_q.push_back(exp);
        // String move steps ESI (6) and EDI (7)
        if (f[8][0]) begin
            model_regs[6] = f[9][0] ? model_regs[6] - bytes : model_regs[6] + bytes;
            model_regs[7] = f[9][0] ? model_regs[7] - bytes : model_regs[7] + bytes;
        end
        if (f[7][0]) begin
            model_esp = model_esp - bytes;
        end else if (f[7][1]) begin
            model_esp = model_esp + bytes;
        end
        @(negedge clk);
        d_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Random back-pressure only for lines that ask for it
    initial begin
        logic stall_now;
        forever begin
            @(posedge clk);
            stall_now = stall_mode;
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            r_ready   = stall_now ? (lcg_state[31:30] != 2'b00) : 1'b1;
        end
    end

    // Output side checker, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            #2;
            if (!reset && r_valid) begin
                if (expected_q.size() == 0) begin
                    $display("Output valid with no instruction outstanding");
                    stop_run();
                end else begin
                    compare_issue(expected_q[0]);
                    if (r_ready) begin
                        void'(expected_q.pop_front());
                    end
                end
            end
        end
    end

    initial begin
        wait (case_count > 0);
        repeat (40 * case_count + 100) @(posedge clk);
        $display("Watchdog expired because the outputs stalled before all cases completed");
        stop_run();
    end

    initial begin
        int          fd;
        int          kind;
        string       line;
        logic [31:0] num;
        logic [31:0] stk;
        logic [31:0] data;
        reset       = 1'b1;
        d_valid     = 1'b0;
        d_instr     = '0;
        wb          = '0;
        flag_df     = 1'b0;
        r_ready     = 1'b1;
        stall_mode  = 1'b0;
        lcg_state   = 32'h4321ebaa;
        model_esp   = '0;
        case_count  = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        fd = $fopen("register_access_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file register_access_cases.txt");
            stop_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    case_lines.push_back(line);
                end
            end
            $fclose(fd);
            case_count = case_lines.size();
            repeat (3) @(negedge clk);
            reset = 1'b0;
            #1;
            check_value("r_valid", r_valid, 32'd0);
            check_value("d_ready", d_ready, 32'd1);
            @(negedge clk);
            foreach (case_lines[i]) begin
                void'($sscanf(case_lines[i], "%d", kind));
                if (kind == 1) begin
                    void'($sscanf(case_lines[i], "%d %h %h %h", kind, num, stk, data));
                    apply_writeback(num, stk, data);
                end else begin
                    issue_instruction(case_lines[i]);
                end
            end
            stall_mode = 1'b0;
            while (expected_q.size() != 0) begin
                @(negedge clk);
            end
            repeat (2) @(negedge clk);
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: verilog.f
ra_pkg.sv
operand_select.sv
gpr_file.sv
stack_tracker.sv
ra_output_stage.sv
register_access_top.sv
tb_register_access.sv
